// ==== Bender.yml ====
package:
  name: fetch_subsys

sources:
  - fetch_pkg.sv
  - instruction_memory.sv
  - instruction_fetch.sv
  - serial_divider.sv
  - serial_shifter.sv
  - fetch_subsys.sv
  - target: test
    files:
      - tb_fetch_subsys.sv

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   // one fetched item handed to decode
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] insn;
   } fetch_out_t;

   typedef struct packed {
      logic [31:0] dividend;
      logic [31:0] divisor;
   } div_req_t;

   typedef struct packed {
      logic [31:0] quotient;
      logic [31:0] remainder;
   } div_res_t;

   // 2'd3 is not used
   typedef enum logic [1:0] {
      sh_sll = 2'd0,
      sh_srl = 2'd1,
      sh_sra = 2'd2
   } shift_op_e;

   typedef struct packed {
      shift_op_e   op;
      logic [31:0] value;
      logic [4:0]  shamt;
   } shift_req_t;

   typedef struct packed {
      logic [31:0] result;
   } shift_res_t;

endpackage

`default_nettype wire

// ==== fetch_subsys.f ====
fetch_pkg.sv
instruction_memory.sv
instruction_fetch.sv
serial_divider.sv
serial_shifter.sv
fetch_subsys.sv
tb_fetch_subsys.sv

// ==== fetch_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_subsys import fetch_pkg::*; #(
   parameter logic [31:0] START_ADDR = 32'h8000_0000,
   parameter int unsigned IMEM_AW    = 10
) (
   input  logic        clk,
   input  logic        rst_n,
   // instruction load port, used while run is low
   input  logic        insn_we,
   input  logic [31:0] insn_addr,
   input  logic [31:0] insn_din,
   input  logic        run,
   input  logic [31:0] pc_in,
   input  logic        pc_in_en,
   input  logic        stall,
   // toward decode
   output fetch_out_t  fetch_out,
   output logic        fetch_valid,
   input  logic        fetch_ready,
   // divider
   input  div_req_t    div_req,
   input  logic        div_req_valid,
   output logic        div_req_ready,
   output div_res_t    div_res,
   output logic        div_res_valid,
   input  logic        div_res_ready,
   // shifter
   input  shift_req_t  shift_req,
   input  logic        shift_req_valid,
   output logic        shift_req_ready,
   output shift_res_t  shift_res,
   output logic        shift_res_valid,
   input  logic        shift_res_ready
);

   logic div_busy;
   logic shift_busy;

   instruction_fetch #(
      .START_ADDR (START_ADDR),
      .IMEM_AW    (IMEM_AW)
   ) u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .run         (run),
      .stall       (stall),
      .div_busy    (div_busy),
      .shift_busy  (shift_busy),
      .pc_in       (pc_in),
      .pc_in_en    (pc_in_en),
      .insn_we     (insn_we),
      .insn_addr   (insn_addr),
      .insn_din    (insn_din),
      .fetch_out   (fetch_out),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready)
   );

   serial_divider u_div (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (div_req),
      .req_valid (div_req_valid),
      .req_ready (div_req_ready),
      .res       (div_res),
      .res_valid (div_res_valid),
      .res_ready (div_res_ready),
      .busy      (div_busy)
   );

   serial_shifter u_shift (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (shift_req),
      .req_valid (shift_req_valid),
      .req_ready (shift_req_ready),
      .res       (shift_res),
      .res_valid (shift_res_valid),
      .res_ready (shift_res_ready),
      .busy      (shift_busy)
   );

endmodule

`default_nettype wire

// ==== instruction_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module instruction_fetch import fetch_pkg::*; #(
   parameter logic [31:0] START_ADDR = 32'h8000_0000,
   parameter int unsigned IMEM_AW    = 10
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        run,
   input  logic        stall,
   input  logic        div_busy,
   input  logic        shift_busy,
   input  logic [31:0] pc_in,
   input  logic        pc_in_en,
   input  logic        insn_we,
   input  logic [31:0] insn_addr,
   input  logic [31:0] insn_din,
   output fetch_out_t  fetch_out,
   output logic        fetch_valid,
   input  logic        fetch_ready
);

   typedef enum logic {
      st_idle,
      st_run
   } state_e;

   state_e      state;
   logic [31:0] pc;        // next address to issue
   logic [31:0] addr_pc;   // pc of the word being read
   logic        inflight;  // rd_data holds a word not yet in fetch_out
   logic        hold;
   logic        load;
   logic        issue;
   logic [31:0] rd_data;

   assign hold = stall | div_busy | shift_busy;

   // a redirect throws away the word being read
   assign load  = inflight & ~pc_in_en & (~fetch_valid | fetch_ready);
   assign issue = (state == st_run) & ~hold & ~pc_in_en & (~inflight | load);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         pc       <= START_ADDR;
         inflight <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (run) begin
                  state <= st_run;
                  pc    <= START_ADDR;
               end
            end
            default: begin
               if (!run) state <= st_idle;
               if (pc_in_en) begin
                  pc <= pc_in;
               end else if (issue) begin
                  pc <= pc + 32'd4;
               end
            end
         endcase

         if (pc_in_en) inflight <= 1'b0;
         else if (issue) inflight <= 1'b1;
         else if (load) inflight <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) addr_pc <= pc;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_valid <= 1'b0;
      end else if (load) begin
         fetch_valid <= 1'b1;
      end else if (fetch_ready) begin
         fetch_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) fetch_out <= '{pc: addr_pc, insn: rd_data};
   end

   instruction_memory #(
      .IMEM_AW (IMEM_AW)
   ) u_imem (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en   (issue),
      .rd_addr (pc[IMEM_AW+1:2]),   // word index, upper pc bits ignored
      .rd_data (rd_data),
      .wr_en   (insn_we),
      .wr_addr (insn_addr[IMEM_AW+1:2]),
      .wr_data (insn_din)
   );

   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      pc[1:0] == 2'b00)
      else $error("fetch pc not word aligned");

   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_out))
      else $error("fetch_out changed under back-pressure");

endmodule

`default_nettype wire

// ==== instruction_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module instruction_memory #(
   parameter int unsigned IMEM_AW = 10
) (
   input  logic               clk,
   input  logic               rst_n,
   // read port, one cycle latency
   input  logic               rd_en,
   input  logic [IMEM_AW-1:0] rd_addr,
   output logic [31:0]        rd_data,
   // load port
   input  logic               wr_en,
   input  logic [IMEM_AW-1:0] wr_addr,
   input  logic [31:0]        wr_data
);

   localparam int unsigned DEPTH = 1 << IMEM_AW;

   logic [31:0] mem [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // output register keeps its word while rd_en is low,
   // fetch relies on this to park a read under back-pressure
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else if (rd_en) begin
         rd_data <= mem[rd_addr];   // old data on same-address write
      end
   end

endmodule

`default_nettype wire

// ==== serial_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

module serial_divider import fetch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  div_req_t req,
   input  logic     req_valid,
   output logic     req_ready,
   output div_res_t res,
   output logic     res_valid,
   input  logic     res_ready,
   output logic     busy
);

   typedef enum logic [1:0] {
      st_idle,
      st_calc,
      st_fin,
      st_done
   } state_e;

   state_e      state;
   logic [4:0]  cnt;
   logic        div_zero;
   logic [31:0] rem_q;
   logic [31:0] quo_q;   // dividend shifts out, quotient shifts in
   logic [31:0] dsr_q;
   logic [32:0] trial;
   logic        accept;

   assign accept    = req_valid & req_ready;
   assign busy      = accept | (state != st_idle);
   assign res_valid = (state == st_done);

   assign trial = {rem_q, quo_q[31]} - {1'b0, dsr_q};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_idle;
         req_ready <= 1'b0;
         cnt       <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  state     <= st_calc;
                  req_ready <= 1'b0;
                  cnt       <= '0;
               end else begin
                  req_ready <= 1'b1;
               end
            end
            st_calc: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) state <= st_fin;
            end
            st_fin: state <= st_done;
            default: if (res_ready) state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rem_q    <= '0;
         quo_q    <= req.dividend;
         dsr_q    <= req.divisor;
         div_zero <= (req.divisor == 32'd0);
      end else if (state == st_calc && !div_zero) begin
         if (!trial[32]) begin
            rem_q <= trial[31:0];
            quo_q <= {quo_q[30:0], 1'b1};
         end else begin
            rem_q <= {rem_q[30:0], quo_q[31]};
            quo_q <= {quo_q[30:0], 1'b0};
         end
      end
      if (state == st_fin) begin
         // quo_q still holds the dividend when dividing by zero
         if (div_zero) res <= '{quotient: '1, remainder: quo_q};
         else res <= '{quotient: quo_q, remainder: rem_q};
      end
   end

   a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready |=> $stable(res))
      else $error("divider result changed before it was taken");

endmodule

`default_nettype wire

// ==== serial_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module serial_shifter import fetch_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  shift_req_t req,
   input  logic       req_valid,
   output logic       req_ready,
   output shift_res_t res,
   output logic       res_valid,
   input  logic       res_ready,
   output logic       busy
);

   typedef enum logic [1:0] {
      st_idle,
      st_shift,
      st_done
   } state_e;

   state_e      state;
   shift_op_e   op_q;
   logic [31:0] val_q;
   logic [4:0]  cnt;     // positions still to shift
   logic        accept;

   assign accept     = req_valid & req_ready;
   assign busy       = accept | (state != st_idle);
   assign res_valid  = (state == st_done);
   assign res.result = val_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_idle;
         req_ready <= 1'b0;
         cnt       <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  state     <= st_shift;
                  req_ready <= 1'b0;
                  cnt       <= req.shamt;
               end else begin
                  req_ready <= 1'b1;
               end
            end
            st_shift: begin
               if (cnt == 5'd0) state <= st_done;
               else cnt <= cnt - 5'd1;
            end
            default: if (res_ready) state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q  <= req.op;
         val_q <= req.value;
      end else if (state == st_shift && cnt != 5'd0) begin
         case (op_q)
            sh_srl:  val_q <= {1'b0, val_q[31:1]};
            sh_sra:  val_q <= {val_q[31], val_q[31:1]};   // sign fill
            default: val_q <= {val_q[30:0], 1'b0};
         endcase
      end
   end

   a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && req_ready |-> state == st_idle)
      else $error("shifter accepted a request while busy");

endmodule

`default_nettype wire

// ==== tb_fetch_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_subsys import fetch_pkg::*; ();

   localparam logic [31:0] START_ADDR = 32'h8000_0000;
   localparam int IMEM_AW = 8;
   localparam int DEPTH = 1 << IMEM_AW;
   localparam int N_OPS = DEPTH + 3 * 100 + 40 + 40;   // loads, fetch items, divides, shifts
   localparam int TIMEOUT_CYC = N_OPS * 40 + 2000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        insn_we;
   logic [31:0] insn_addr;
   logic [31:0] insn_din;
   logic        run;
   logic [31:0] pc_in;
   logic        pc_in_en;
   logic        stall;
   fetch_out_t  fetch_out;
   logic        fetch_valid;
   logic        fetch_ready;
   div_req_t    div_req;
   logic        div_req_valid;
   logic        div_req_ready;
   div_res_t    div_res;
   logic        div_res_valid;
   logic        div_res_ready;
   shift_req_t  shift_req;
   logic        shift_req_valid;
   logic        shift_req_ready;
   shift_res_t  shift_res;
   logic        shift_res_valid;
   logic        shift_res_ready;

   logic [31:0] seed;
   logic [31:0] model_mem [0:DEPTH-1];
   int          cyc = 0;
   int          errors = 0;
   int          err_div = 0;
   int          tests_run = 0;
   int          tests_bad = 0;

   // stimulus modes for the fetch side
   logic drive_fetch = 1'b0;
   logic rand_ready  = 1'b0;
   logic rand_stall  = 1'b0;
   logic rand_redir  = 1'b0;

   // fetch model state
   logic [31:0] exp_pc = START_ADDR;
   logic        pend_valid = 1'b0;   // redirect seen while an old item sat in fetch_out
   logic [31:0] pend_pc;
   logic        out_held = 1'b0;
   fetch_out_t  held_item;
   fetch_out_t  exp_item;
   int          held_accepts = 0;
   int          fetch_acc = 0;
   int          redirects = 0;

   // unit model state
   logic        div_open = 1'b0;
   logic        div_seen = 1'b0;
   logic        div_busy_m;
   div_res_t    div_exp;
   int          div_t0;
   int          div_done = 0;
   logic        shift_open = 1'b0;
   logic        shift_seen = 1'b0;
   logic        shift_busy_m;
   shift_res_t  shift_exp;
   int          shift_t0;
   int          shift_lat;
   int          shift_done = 0;

   fetch_subsys #(
      .START_ADDR (START_ADDR),
      .IMEM_AW    (IMEM_AW)
   ) DUT (
      .clk             (clk),
      .rst_n           (rst_n),
      .insn_we         (insn_we),
      .insn_addr       (insn_addr),
      .insn_din        (insn_din),
      .run             (run),
      .pc_in           (pc_in),
      .pc_in_en        (pc_in_en),
      .stall           (stall),
      .fetch_out       (fetch_out),
      .fetch_valid     (fetch_valid),
      .fetch_ready     (fetch_ready),
      .div_req         (div_req),
      .div_req_valid   (div_req_valid),
      .div_req_ready   (div_req_ready),
      .div_res         (div_res),
      .div_res_valid   (div_res_valid),
      .div_res_ready   (div_res_ready),
      .shift_req       (shift_req),
      .shift_req_valid (shift_req_valid),
      .shift_req_ready (shift_req_ready),
      .shift_res       (shift_res),
      .shift_res_valid (shift_res_valid),
      .shift_res_ready (shift_res_ready)
   );

   always #10 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic div_res_t div_model(input div_req_t r);
      div_res_t o;
      if (r.divisor == 32'd0) begin
         o.quotient  = '1;
         o.remainder = r.dividend;
      end else begin
         o.quotient  = r.dividend / r.divisor;
         o.remainder = r.dividend % r.divisor;
      end
      return o;
   endfunction

   function automatic shift_res_t shift_model(input shift_req_t r);
      shift_res_t o;
      case (r.op)
         sh_sll:  o.result = r.value << r.shamt;
         sh_srl:  o.result = r.value >> r.shamt;
         default: o.result = $signed(r.value) >>> r.shamt;
      endcase
      return o;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_fetch(input string name, input fetch_out_t exp, input fetch_out_t act);
      if (act !== exp) begin
         $display("MISMATCH %0t %s expected pc=%h insn=%h actual pc=%h insn=%h",
                  $time, name, exp.pc, exp.insn, act.pc, act.insn);
         errors++;
      end
   endtask

   task automatic check_div(input string name, input div_res_t exp, input div_res_t act);
      if (act !== exp) begin
         $display("MISMATCH %0t %s expected q=%h r=%h actual q=%h r=%h",
                  $time, name, exp.quotient, exp.remainder, act.quotient, act.remainder);
         errors++;
         err_div++;
      end
   endtask

   task automatic check_shift(input string name, input shift_res_t exp, input shift_res_t act);
      if (act !== exp) begin
         $display("MISMATCH %0t %s expected %h actual %h", $time, name, exp.result, act.result);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int bad);
      tests_run++;
      if (bad != 0) tests_bad++;
      $display("test %0d %-13s %s (%0d errors)", num, name, (bad == 0) ? "ok" : "bad", bad);
   endtask

   // fetch-side stimulus, one decision per rising edge
   always @(posedge clk) begin
      if (drive_fetch) begin
         fetch_ready <= rand_ready ? (($random(seed) & 32'h3) != 0) : 1'b1;
         stall       <= rand_stall && (($random(seed) & 32'h7) == 0);
         pc_in_en    <= 1'b0;
         if (rand_redir && !pc_in_en && (($random(seed) & 32'hf) == 0)) begin
            pc_in_en <= 1'b1;
            pc_in    <= START_ADDR | (($random(seed) & (DEPTH - 1)) << 2);
         end
      end
   end

   // outputs are stable here; each check covers the transfer at the next rising edge
   always @(negedge clk) begin
      if (rst_n) begin
         div_busy_m   = (div_req_valid & div_req_ready) | div_open;
         shift_busy_m = (shift_req_valid & shift_req_ready) | shift_open;

         if (out_held) begin
            if (!fetch_valid) report_error("fetch_valid dropped before the item was taken");
            check_fetch("fetch_out", held_item, fetch_out);
         end
         out_held  = fetch_valid & ~fetch_ready;
         held_item = fetch_out;

         if (fetch_valid && fetch_ready) begin
            exp_item = '{pc: exp_pc, insn: model_mem[exp_pc[IMEM_AW+1:2]]};
            check_fetch("fetch_out", exp_item, fetch_out);
            fetch_acc++;
            exp_pc = exp_pc + 32'd4;
            if (pend_valid) begin
               exp_pc     = pend_pc;
               pend_valid = 1'b0;
            end
         end

         // at most the item in fetch_out and the one being read drain under hold
         if (!(stall | div_busy_m | shift_busy_m)) begin
            held_accepts = 0;
         end else if (fetch_valid && fetch_ready) begin
            held_accepts++;
            if (held_accepts > 2) report_error("fetch issued a new item while held");
         end

         if (pc_in_en) begin
            redirects++;
            if (fetch_valid && !fetch_ready) begin
               pend_valid = 1'b1;
               pend_pc    = pc_in;
            end else begin
               exp_pc     = pc_in;
               pend_valid = 1'b0;
            end
         end

         if (div_req_valid && div_req_ready) begin
            div_exp  = div_model(div_req);
            div_open = 1'b1;
            div_t0   = cyc + 1;
         end
         if (div_res_valid && !div_seen) begin
            div_seen = 1'b1;
            if (!div_open) report_error("divider result appeared without a request");
            if (cyc - div_t0 != 33) begin
               report_error($sformatf("divider latency %0d cycles, expected 33", cyc - div_t0));
               err_div++;
            end
         end
         if (div_res_valid && div_res_ready) begin
            check_div("div_res", div_exp, div_res);
            div_open = 1'b0;
            div_seen = 1'b0;
            div_done++;
         end

         if (shift_req_valid && shift_req_ready) begin
            shift_exp  = shift_model(shift_req);
            shift_lat  = shift_req.shamt + 1;
            shift_open = 1'b1;
            shift_t0   = cyc + 1;
         end
         if (shift_res_valid && !shift_seen) begin
            shift_seen = 1'b1;
            if (!shift_open) report_error("shifter result appeared without a request");
            if (cyc - shift_t0 != shift_lat) begin
               report_error($sformatf("shifter latency %0d cycles, expected %0d",
                                      cyc - shift_t0, shift_lat));
            end
         end
         if (shift_res_valid && shift_res_ready) begin
            check_shift("shift_res", shift_exp, shift_res);
            shift_open = 1'b0;
            shift_seen = 1'b0;
            shift_done++;
         end
      end
   end

   task automatic wait_items(input int n);
      int target;
      target = fetch_acc + n;
      while (fetch_acc < target) @(posedge clk);
   endtask

   task automatic run_divs(input int n);
      div_req_t r;
      int       k;
      for (k = 0; k < n; k++) begin
         r.dividend = $random(seed);
         case (k % 8)
            0:       r.divisor = 32'd0;
            1:       r.divisor = 32'd1;
            2:       r.divisor = $random(seed) & 32'hff;
            default: r.divisor = $random(seed);
         endcase
         @(posedge clk);
         div_req       <= r;
         div_req_valid <= 1'b1;
         @(negedge clk);
         while (!div_req_ready) @(negedge clk);
         @(posedge clk);
         div_req_valid <= 1'b0;
         while (!div_res_valid) @(negedge clk);
         repeat ($random(seed) & 32'h3) @(posedge clk);   // hold the result a while
         @(posedge clk);
         div_res_ready <= 1'b1;
         @(posedge clk);
         div_res_ready <= 1'b0;
      end
   endtask

   task automatic run_shifts(input int n);
      shift_req_t r;
      int         k;
      for (k = 0; k < n; k++) begin
         r.op    = shift_op_e'(k % 3);
         r.value = $random(seed);
         r.shamt = 5'((k * 7) % 32);   // every amount within 32 requests
         @(posedge clk);
         shift_req       <= r;
         shift_req_valid <= 1'b1;
         @(negedge clk);
         while (!shift_req_ready) @(negedge clk);
         @(posedge clk);
         shift_req_valid <= 1'b0;
         while (!shift_res_valid) @(negedge clk);
         repeat ($random(seed) & 32'h3) @(posedge clk);
         @(posedge clk);
         shift_res_ready <= 1'b1;
         @(posedge clk);
         shift_res_ready <= 1'b0;
      end
   endtask

   initial begin
      seed            = 32'hb040;
      rst_n           = 1'b0;
      run             = 1'b0;
      insn_we         = 1'b0;
      insn_addr       = '0;
      insn_din        = '0;
      pc_in           = '0;
      pc_in_en        = 1'b0;
      stall           = 1'b0;
      fetch_ready     = 1'b0;
      div_req         = '0;
      div_req_valid   = 1'b0;
      div_res_ready   = 1'b0;
      shift_req       = '0;
      shift_req_valid = 1'b0;
      shift_res_ready = 1'b0;
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int          i;
      int          mark;
      int          mark_div;
      logic [31:0] w;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (i = 0; i < DEPTH; i++) begin
         @(posedge clk);
         w            = $random(seed);
         model_mem[i] = w;
         insn_we      <= 1'b1;
         insn_addr    <= START_ADDR + 32'(i * 4);
         insn_din     <= w;
      end
      @(posedge clk);
      insn_we <= 1'b0;

      @(negedge clk);
      mark        = errors;
      drive_fetch = 1'b1;
      @(posedge clk);
      run <= 1'b1;
      wait_items(100);
      report_test(1, "sequential", errors - mark);

      @(negedge clk);
      mark       = errors;
      rand_ready = 1'b1;
      rand_stall = 1'b1;
      wait_items(100);
      report_test(2, "backpressure", errors - mark);

      @(negedge clk);
      mark       = errors;
      rand_stall = 1'b0;
      rand_redir = 1'b1;
      wait_items(100);
      if (redirects == 0) report_error("no redirect was issued");
      report_test(3, "redirect", errors - mark);

      // fetch keeps running beside both units
      @(negedge clk);
      mark       = errors;
      mark_div   = err_div;
      rand_redir = 1'b0;
      rand_stall = 1'b1;
      fork
         run_divs(40);
         run_shifts(40);
      join
      repeat (2) @(negedge clk);
      drive_fetch = 1'b0;
      if (div_done != 40) report_error("not every divide result was taken");
      if (shift_done != 40) report_error("not every shift result was taken");
      report_test(4, "division", err_div - mark_div);
      report_test(5, "shifts", errors - mark - (err_div - mark_div));

      $display("summary: %0d tests, %0d with errors, %0d items, %0d divides, %0d shifts, %0d errors",
               tests_run, tests_bad, fetch_acc, div_done, shift_done, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
